/* branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module branch_unit import isa_pkg::*; (
  input  xlen_t  pc_i,
  input  xlen_t  rs1_data_i,
  input  xlen_t  rs2_data_i,
  input  xlen_t  imm_i,
  input  pc_op_t pc_op_i,
  output logic   taken_o,
  output xlen_t  target_o
);

  xlen_t pc_rel;
  xlen_t reg_rel;
  logic  eq;
  logic  lt_s;
  logic  lt_u;

  assign pc_rel  = pc_i + imm_i;
  assign reg_rel = rs1_data_i + imm_i;

  assign eq   = (rs1_data_i == rs2_data_i);
  assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign lt_u = (rs1_data_i < rs2_data_i);

  always_comb begin
    taken_o  = 1'b0;
    target_o = pc_rel;  // jal and all conditional branches
    case (pc_op_i)
      PCOP_JAL:  taken_o = 1'b1;
      PCOP_JALR: begin
        taken_o  = 1'b1;
        target_o = {reg_rel[`XLEN-1:1], 1'b0};  // lsb cleared per spec
      end
      PCOP_BEQ:  taken_o = eq;
      PCOP_BNE:  taken_o = !eq;
      PCOP_BLT:  taken_o = lt_s;
      PCOP_BGE:  taken_o = !lt_s;
      PCOP_BLTU: taken_o = lt_u;
      PCOP_BGEU: taken_o = !lt_u;
      default:   taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath widths
`define XLEN           64
`define INST_LEN       32
`define REG_ADDRWIDTH  5
`define CSR_ADDRWIDTH  12

// decoded operation code widths
`define ALUOP_LEN      5
`define MEMOP_LEN      4
`define EXCOP_LEN      3
`define PCOP_LEN       4
`define CSROP_LEN      3

`define TRAP_LEN       8

// stall and flush buses, one bit per stage
`define CTRLBUS_LEN    6
`define CTRLBUS_PC     0
`define CTRLBUS_IF_ID  1
`define CTRLBUS_ID_EX  2
`define CTRLBUS_EX_MEM 3
`define CTRLBUS_MEM_WB 4
`define CTRLBUS_WB     5

// addi x0, x0, 0
`define INST_NOP       32'h00000013

`endif

/* id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module id_ex_reg import isa_pkg::*, pipe_pkg::*; (
  input  wire        clk,
  input  wire        rst_n_i,
  input  ctrl_bus_t  stall_valid_i,
  input  ctrl_bus_t  flush_valid_i,
  input  xlen_t      pc_i,
  input  inst_t      inst_i,
  input  reg_idx_t   rs1_idx_i,
  input  reg_idx_t   rs2_idx_i,
  input  reg_idx_t   rd_idx_i,
  input  xlen_t      imm_i,
  input  xlen_t      csr_imm_i,
  input  logic       csr_imm_valid_i,
  input  xlen_t      rs1_data_i,
  input  xlen_t      rs2_data_i,
  input  xlen_t      csr_data_i,
  input  csr_idx_t   csr_idx_i,
  input  alu_op_t    alu_op_i,
  input  mem_op_t    mem_op_i,
  input  exc_op_t    exc_op_i,
  input  pc_op_t     pc_op_i,
  input  csr_op_t    csr_op_i,
  input  trap_bus_t  trap_bus_i,
  output xlen_t      pc_o,
  output inst_t      inst_o,
  output reg_idx_t   rs1_idx_o,
  output reg_idx_t   rs2_idx_o,
  output reg_idx_t   rd_idx_o,
  output xlen_t      imm_o,
  output xlen_t      csr_imm_o,
  output logic       csr_imm_valid_o,
  output xlen_t      rs1_data_o,
  output xlen_t      rs2_data_o,
  output xlen_t      csr_data_o,
  output csr_idx_t   csr_idx_o,
  output alu_op_t    alu_op_o,
  output mem_op_t    mem_op_o,
  output exc_op_t    exc_op_o,
  output pc_op_t     pc_op_o,
  output csr_op_t    csr_op_o,
  output trap_bus_t  trap_bus_o
);

  logic hold;
  logic bubble;

  assign hold   = stall_valid_i[`CTRLBUS_ID_EX];
  assign bubble = flush_valid_i[`CTRLBUS_ID_EX];  // load a nop into ex

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o            <= '0;
      inst_o          <= `INST_NOP;
      rs1_idx_o       <= '0;
      rs2_idx_o       <= '0;
      rd_idx_o        <= '0;
      imm_o           <= '0;
      csr_imm_o       <= '0;
      csr_imm_valid_o <= 1'b0;
      rs1_data_o      <= '0;
      rs2_data_o      <= '0;
      csr_data_o      <= '0;
      csr_idx_o       <= '0;
      alu_op_o        <= ALUOP_NONE;
      mem_op_o        <= MEMOP_NONE;
      exc_op_o        <= EXCOP_NONE;
      pc_op_o         <= PCOP_NONE;
      csr_op_o        <= CSROP_NONE;
      trap_bus_o      <= '0;
    end else if (!hold) begin
      if (bubble) begin
        pc_o            <= '0;
        inst_o          <= `INST_NOP;
        rs1_idx_o       <= '0;
        rs2_idx_o       <= '0;
        rd_idx_o        <= '0;
        imm_o           <= '0;
        csr_imm_o       <= '0;
        csr_imm_valid_o <= 1'b0;
        rs1_data_o      <= '0;
        rs2_data_o      <= '0;
        csr_data_o      <= '0;
        csr_idx_o       <= '0;
        alu_op_o        <= ALUOP_NONE;
        mem_op_o        <= MEMOP_NONE;
        exc_op_o        <= EXCOP_NONE;
        pc_op_o         <= PCOP_NONE;
        csr_op_o        <= CSROP_NONE;
        trap_bus_o      <= '0;
      end else begin
        pc_o            <= pc_i;
        inst_o          <= inst_i;
        rs1_idx_o       <= rs1_idx_i;
        rs2_idx_o       <= rs2_idx_i;
        rd_idx_o        <= rd_idx_i;
        imm_o           <= imm_i;
        csr_imm_o       <= csr_imm_i;
        csr_imm_valid_o <= csr_imm_valid_i;
        rs1_data_o      <= rs1_data_i;
        rs2_data_o      <= rs2_data_i;
        csr_data_o      <= csr_data_i;
        csr_idx_o       <= csr_idx_i;
        alu_op_o        <= alu_op_i;
        mem_op_o        <= mem_op_i;
        exc_op_o        <= exc_op_i;
        pc_op_o         <= pc_op_i;
        csr_op_o        <= csr_op_i;
        trap_bus_o      <= trap_bus_i;
      end
    end
  end

endmodule

`default_nettype wire

/* idex_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module idex_stage_checker import pipe_pkg::*; (
  input wire       clk,
  input wire       rst_n_i,
  input logic      mem_stall_i,
  input ctrl_bus_t stall_i,
  input ctrl_bus_t flush_i,
  input logic      redirect_i
);

  // a stage is frozen or killed, never both
  stall_flush_disjoint_a: assert property (
    @(posedge clk) disable iff (!rst_n_i) (stall_i & flush_i) == '0
  ) else $error("stall and flush buses share a set bit");

  redirect_flushes_idex_a: assert property (
    @(posedge clk) disable iff (!rst_n_i) redirect_i |-> flush_i[`CTRLBUS_ID_EX]
  ) else $error("redirect without id_ex flush");

  mem_stall_no_flush_a: assert property (
    @(posedge clk) disable iff (!rst_n_i) mem_stall_i |-> (flush_i == '0)
  ) else $error("flush bus active during memory stall");

endmodule

bind idex_stage_top idex_stage_checker checker_i (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .mem_stall_i (mem_stall_i),
  .stall_i     (stall_valid_o),
  .flush_i     (flush_valid_o),
  .redirect_i  (redirect_valid_o)
);

`default_nettype wire

/* idex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module idex_stage_tb import isa_pkg::*, pipe_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 400;  // tests take about 170 cycles

  wire       clk;
  wire       rst_n_i;
  logic      mem_stall_i;
  xlen_t     pc_i, imm_i, csr_imm_i, rs1_data_i, rs2_data_i, csr_data_i;
  inst_t     inst_i;
  reg_idx_t  rs1_idx_i, rs2_idx_i, rd_idx_i;
  logic      csr_imm_valid_i;
  csr_idx_t  csr_idx_i;
  alu_op_t   alu_op_i;
  mem_op_t   mem_op_i;
  exc_op_t   exc_op_i;
  pc_op_t    pc_op_i;
  csr_op_t   csr_op_i;
  trap_bus_t trap_bus_i;
  xlen_t     ex_pc_o, ex_imm_o, ex_csr_imm_o, ex_rs1_data_o, ex_rs2_data_o, ex_csr_data_o;
  inst_t     ex_inst_o;
  reg_idx_t  ex_rs1_idx_o, ex_rs2_idx_o, ex_rd_idx_o;
  logic      ex_csr_imm_valid_o;
  csr_idx_t  ex_csr_idx_o;
  alu_op_t   ex_alu_op_o;
  mem_op_t   ex_mem_op_o;
  exc_op_t   ex_exc_op_o;
  pc_op_t    ex_pc_op_o;
  csr_op_t   ex_csr_op_o;
  trap_bus_t ex_trap_bus_o;
  ctrl_bus_t stall_valid_o, flush_valid_o;
  logic      redirect_valid_o;
  xlen_t     redirect_pc_o;

  logic [31:0] lfsr_state = 32'h07a6c028;
  int unsigned cycles = 0;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n_i));

  idex_stage_top dut_i (.*);

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_mismatch(input string name, input string got, input string exp);
    $display("mismatch %s: got 0x%s, expected 0x%s", name, got, exp);
    stop_on_failure();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  // bus invariants, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n_i) begin
      if ((stall_valid_o & flush_valid_o) != '0) begin
        $display("stall and flush buses share a set bit");
        stop_on_failure();
      end
      if (redirect_valid_o && !flush_valid_o[`CTRLBUS_ID_EX]) begin
        $display("redirect raised without the id_ex flush");
        stop_on_failure();
      end
      if (mem_stall_i && flush_valid_o != '0) begin
        $display("flush bus active during a memory stall");
        stop_on_failure();
      end
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[`XLEN-2:0], lfsr_bit()};
    return v;
  endfunction

  task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_csr_idx(input string name, input csr_idx_t got, input csr_idx_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_mem_op(input string name, input mem_op_t got, input mem_op_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_exc_op(input string name, input exc_op_t got, input exc_op_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_pc_op(input string name, input pc_op_t got, input pc_op_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_csr_op(input string name, input csr_op_t got, input csr_op_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_trap(input string name, input trap_bus_t got, input trap_bus_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_bus(input string name, input ctrl_bus_t got, input ctrl_bus_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0h", got), $sformatf("%0h", exp));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_random(input mem_op_t mop, input pc_op_t pop);
    pc_i            = rand_bits(64);
    inst_i          = inst_t'(rand_bits(32));
    rs1_idx_i       = reg_idx_t'(rand_bits(5));
    rs2_idx_i       = reg_idx_t'(rand_bits(5));
    rd_idx_i        = reg_idx_t'(rand_bits(5));
    imm_i           = rand_bits(64);
    csr_imm_i       = rand_bits(64);
    csr_imm_valid_i = lfsr_bit();
    rs1_data_i      = rand_bits(64);
    rs2_data_i      = rand_bits(64);
    csr_data_i      = rand_bits(64);
    csr_idx_i       = csr_idx_t'(rand_bits(12));
    alu_op_i        = alu_op_t'(rand_bits(5));
    mem_op_i        = mop;
    exc_op_i        = exc_op_t'(rand_bits(3));
    pc_op_i         = pop;
    csr_op_i        = csr_op_t'(rand_bits(3));
    trap_bus_i      = trap_bus_t'(rand_bits(8));
  endtask

  // ex fields against the bubble values or the item still on the id inputs
  task automatic check_ex(input logic bubble);
    check_xlen("ex_pc_o", ex_pc_o, bubble ? '0 : pc_i);
    check_inst("ex_inst_o", ex_inst_o, bubble ? `INST_NOP : inst_i);
    check_idx("ex_rs1_idx_o", ex_rs1_idx_o, bubble ? '0 : rs1_idx_i);
    check_idx("ex_rs2_idx_o", ex_rs2_idx_o, bubble ? '0 : rs2_idx_i);
    check_idx("ex_rd_idx_o", ex_rd_idx_o, bubble ? '0 : rd_idx_i);
    check_xlen("ex_imm_o", ex_imm_o, bubble ? '0 : imm_i);
    check_xlen("ex_csr_imm_o", ex_csr_imm_o, bubble ? '0 : csr_imm_i);
    check_bit("ex_csr_imm_valid_o", ex_csr_imm_valid_o, bubble ? 1'b0 : csr_imm_valid_i);
    check_xlen("ex_rs1_data_o", ex_rs1_data_o, bubble ? '0 : rs1_data_i);
    check_xlen("ex_rs2_data_o", ex_rs2_data_o, bubble ? '0 : rs2_data_i);
    check_xlen("ex_csr_data_o", ex_csr_data_o, bubble ? '0 : csr_data_i);
    check_csr_idx("ex_csr_idx_o", ex_csr_idx_o, bubble ? '0 : csr_idx_i);
    check_alu_op("ex_alu_op_o", ex_alu_op_o, bubble ? ALUOP_NONE : alu_op_i);
    check_mem_op("ex_mem_op_o", ex_mem_op_o, bubble ? MEMOP_NONE : mem_op_i);
    check_exc_op("ex_exc_op_o", ex_exc_op_o, bubble ? EXCOP_NONE : exc_op_i);
    check_pc_op("ex_pc_op_o", ex_pc_op_o, bubble ? PCOP_NONE : pc_op_i);
    check_csr_op("ex_csr_op_o", ex_csr_op_o, bubble ? CSROP_NONE : csr_op_i);
    check_trap("ex_trap_bus_o", ex_trap_bus_o, bubble ? '0 : trap_bus_i);
  endtask

  task automatic check_ctrl(input ctrl_bus_t stall_exp, input ctrl_bus_t flush_exp,
                            input logic redirect_exp);
    check_bus("stall_valid_o", stall_valid_o, stall_exp);
    check_bus("flush_valid_o", flush_valid_o, flush_exp);
    check_bit("redirect_valid_o", redirect_valid_o, redirect_exp);
  endtask

  task automatic test_reset();
    @(posedge rst_n_i);
    #1;
    check_ex(1'b1);
    check_ctrl('0, '0, 1'b0);
  endtask

  task automatic test_passthrough();
    next_cycle();
    drive_random(MEMOP_NONE, PCOP_NONE);
    for (int n = 0; n < 20; n++) begin
      next_cycle();
      check_ex(1'b0);
      drive_random(MEMOP_NONE, PCOP_NONE);
      #1;
      check_ctrl('0, '0, 1'b0);
    end
  endtask

  task automatic test_mem_stall();
    xlen_t    held_pc;
    xlen_t    held_imm;
    inst_t    held_inst;
    reg_idx_t held_rd;
    next_cycle();
    drive_random(MEMOP_NONE, PCOP_JAL);
    held_pc   = pc_i;
    held_imm  = imm_i;
    held_inst = inst_i;
    held_rd   = rd_idx_i;
    next_cycle();
    mem_stall_i = 1'b1;  // jal now sits in ex
    drive_random(MEMOP_NONE, PCOP_NONE);
    #1;
    check_ctrl(6'b011111, '0, 1'b0);
    for (int n = 0; n < 3; n++) begin
      next_cycle();
      check_xlen("ex_pc_o", ex_pc_o, held_pc);
      check_xlen("ex_imm_o", ex_imm_o, held_imm);
      check_inst("ex_inst_o", ex_inst_o, held_inst);
      check_idx("ex_rd_idx_o", ex_rd_idx_o, held_rd);
      check_pc_op("ex_pc_op_o", ex_pc_op_o, PCOP_JAL);
      drive_random(MEMOP_NONE, PCOP_NONE);
      #1;
      check_ctrl(6'b011111, '0, 1'b0);
    end
    next_cycle();
    mem_stall_i = 1'b0;
    #1;
    check_ctrl('0, 6'b000110, 1'b1);
    check_xlen("redirect_pc_o", redirect_pc_o, held_pc + held_imm);
    next_cycle();
    check_ex(1'b1);
  endtask

  task automatic load_use_case(input mem_op_t mop, input reg_idx_t rd, input reg_idx_t rs1,
                               input reg_idx_t rs2);
    logic is_load;
    logic hazard;
    is_load = (mop >= MEMOP_LB) && (mop <= MEMOP_LWU);
    hazard  = is_load && (rd != '0) && (rd == rs1 || rd == rs2);
    next_cycle();
    drive_random(mop, PCOP_NONE);
    rd_idx_i = rd;
    next_cycle();
    drive_random(MEMOP_NONE, PCOP_NONE);
    rs1_idx_i = rs1;
    rs2_idx_i = rs2;
    #1;
    if (hazard)
      check_ctrl(6'b000011, 6'b000100, 1'b0);  // freeze pc and if/id, bubble ex
    else
      check_ctrl('0, '0, 1'b0);
    next_cycle();
    check_ex(hazard);
  endtask

  task automatic test_load_use();
    load_use_case(MEMOP_LW, 5'd5, 5'd5, 5'd7);
    load_use_case(MEMOP_LBU, 5'd12, 5'd3, 5'd12);
    load_use_case(MEMOP_LD, 5'd0, 5'd0, 5'd0);
    load_use_case(MEMOP_LH, 5'd9, 5'd3, 5'd4);
    load_use_case(MEMOP_SW, 5'd6, 5'd6, 5'd6);
    load_use_case(MEMOP_LWU, 5'd31, 5'd31, 5'd31);
  endtask

  task automatic branch_case(input pc_op_t op, input xlen_t a, input xlen_t b);
    xlen_t br_pc;
    xlen_t br_imm;
    logic  exp_taken;
    xlen_t exp_target;
    next_cycle();
    drive_random(MEMOP_NONE, op);
    rs1_data_i = a;
    rs2_data_i = b;
    br_pc      = pc_i;
    br_imm     = imm_i;
    exp_target = br_pc + br_imm;
    case (op)
      PCOP_JAL:  exp_taken = 1'b1;
      PCOP_JALR: begin
        exp_taken  = 1'b1;
        exp_target = (a + br_imm) & ~64'd1;
      end
      PCOP_BEQ:  exp_taken = (a == b);
      PCOP_BNE:  exp_taken = (a != b);
      PCOP_BLT:  exp_taken = ($signed(a) < $signed(b));
      PCOP_BGE:  exp_taken = ($signed(a) >= $signed(b));
      PCOP_BLTU: exp_taken = (a < b);
      PCOP_BGEU: exp_taken = (a >= b);
      default:   exp_taken = 1'b0;
    endcase
    next_cycle();
    drive_random(MEMOP_NONE, PCOP_NONE);
    #1;
    if (exp_taken)
      check_ctrl('0, 6'b000110, 1'b1);
    else
      check_ctrl('0, '0, 1'b0);
    if (op != PCOP_NONE && op <= PCOP_BGEU)
      check_xlen("redirect_pc_o", redirect_pc_o, exp_target);
    next_cycle();
    check_ex(exp_taken);
  endtask

  task automatic test_branches();
    xlen_t r;
    for (int op = 0; op < 10; op++) begin
      r = rand_bits(64);
      branch_case(pc_op_t'(op), r, r);
      branch_case(pc_op_t'(op), 64'hffff_ffff_ffff_fff0, 64'd5);  // -16 vs 5
      branch_case(pc_op_t'(op), 64'd5, 64'hffff_ffff_ffff_fff0);
      branch_case(pc_op_t'(op), rand_bits(64), rand_bits(64));
    end
  endtask

  initial begin
    mem_stall_i = 1'b0;
    drive_random(MEMOP_NONE, PCOP_NONE);
    test_reset();
    test_passthrough();
    test_mem_stall();
    test_load_use();
    test_branches();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* idex_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module idex_stage_top import isa_pkg::*, pipe_pkg::*; (
  input  wire        clk,
  input  wire        rst_n_i,
  input  logic       mem_stall_i,
  input  xlen_t      pc_i,
  input  inst_t      inst_i,
  input  reg_idx_t   rs1_idx_i,
  input  reg_idx_t   rs2_idx_i,
  input  reg_idx_t   rd_idx_i,
  input  xlen_t      imm_i,
  input  xlen_t      csr_imm_i,
  input  logic       csr_imm_valid_i,
  input  xlen_t      rs1_data_i,
  input  xlen_t      rs2_data_i,
  input  xlen_t      csr_data_i,
  input  csr_idx_t   csr_idx_i,
  input  alu_op_t    alu_op_i,
  input  mem_op_t    mem_op_i,
  input  exc_op_t    exc_op_i,
  input  pc_op_t     pc_op_i,
  input  csr_op_t    csr_op_i,
  input  trap_bus_t  trap_bus_i,
  output xlen_t      ex_pc_o,
  output inst_t      ex_inst_o,
  output reg_idx_t   ex_rs1_idx_o,
  output reg_idx_t   ex_rs2_idx_o,
  output reg_idx_t   ex_rd_idx_o,
  output xlen_t      ex_imm_o,
  output xlen_t      ex_csr_imm_o,
  output logic       ex_csr_imm_valid_o,
  output xlen_t      ex_rs1_data_o,
  output xlen_t      ex_rs2_data_o,
  output xlen_t      ex_csr_data_o,
  output csr_idx_t   ex_csr_idx_o,
  output alu_op_t    ex_alu_op_o,
  output mem_op_t    ex_mem_op_o,
  output exc_op_t    ex_exc_op_o,
  output pc_op_t     ex_pc_op_o,
  output csr_op_t    ex_csr_op_o,
  output trap_bus_t  ex_trap_bus_o,
  output ctrl_bus_t  stall_valid_o,
  output ctrl_bus_t  flush_valid_o,
  output logic       redirect_valid_o,
  output xlen_t      redirect_pc_o
);

  logic ex_taken;

  id_ex_reg u_id_ex_reg (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .stall_valid_i   (stall_valid_o),
    .flush_valid_i   (flush_valid_o),
    .pc_i            (pc_i),
    .inst_i          (inst_i),
    .rs1_idx_i       (rs1_idx_i),
    .rs2_idx_i       (rs2_idx_i),
    .rd_idx_i        (rd_idx_i),
    .imm_i           (imm_i),
    .csr_imm_i       (csr_imm_i),
    .csr_imm_valid_i (csr_imm_valid_i),
    .rs1_data_i      (rs1_data_i),
    .rs2_data_i      (rs2_data_i),
    .csr_data_i      (csr_data_i),
    .csr_idx_i       (csr_idx_i),
    .alu_op_i        (alu_op_i),
    .mem_op_i        (mem_op_i),
    .exc_op_i        (exc_op_i),
    .pc_op_i         (pc_op_i),
    .csr_op_i        (csr_op_i),
    .trap_bus_i      (trap_bus_i),
    .pc_o            (ex_pc_o),
    .inst_o          (ex_inst_o),
    .rs1_idx_o       (ex_rs1_idx_o),
    .rs2_idx_o       (ex_rs2_idx_o),
    .rd_idx_o        (ex_rd_idx_o),
    .imm_o           (ex_imm_o),
    .csr_imm_o       (ex_csr_imm_o),
    .csr_imm_valid_o (ex_csr_imm_valid_o),
    .rs1_data_o      (ex_rs1_data_o),
    .rs2_data_o      (ex_rs2_data_o),
    .csr_data_o      (ex_csr_data_o),
    .csr_idx_o       (ex_csr_idx_o),
    .alu_op_o        (ex_alu_op_o),
    .mem_op_o        (ex_mem_op_o),
    .exc_op_o        (ex_exc_op_o),
    .pc_op_o         (ex_pc_op_o),
    .csr_op_o        (ex_csr_op_o),
    .trap_bus_o      (ex_trap_bus_o)
  );

  branch_unit u_branch_unit (
    .pc_i       (ex_pc_o),
    .rs1_data_i (ex_rs1_data_o),
    .rs2_data_i (ex_rs2_data_o),
    .imm_i      (ex_imm_o),
    .pc_op_i    (ex_pc_op_o),
    .taken_o    (ex_taken),
    .target_o   (redirect_pc_o)
  );

  // hazard compare uses the id-side source indices
  pipe_ctrl u_pipe_ctrl (
    .mem_stall_i      (mem_stall_i),
    .taken_i          (ex_taken),
    .id_rs1_idx_i     (rs1_idx_i),
    .id_rs2_idx_i     (rs2_idx_i),
    .ex_rd_idx_i      (ex_rd_idx_o),
    .ex_mem_op_i      (ex_mem_op_o),
    .stall_valid_o    (stall_valid_o),
    .flush_valid_o    (flush_valid_o),
    .redirect_valid_o (redirect_valid_o)
  );

endmodule

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]          xlen_t;
  typedef logic [`INST_LEN-1:0]      inst_t;
  typedef logic [`REG_ADDRWIDTH-1:0] reg_idx_t;
  typedef logic [`CSR_ADDRWIDTH-1:0] csr_idx_t;
  typedef logic [`ALUOP_LEN-1:0]     alu_op_t;
  typedef logic [`MEMOP_LEN-1:0]     mem_op_t;
  typedef logic [`EXCOP_LEN-1:0]     exc_op_t;
  typedef logic [`PCOP_LEN-1:0]      pc_op_t;
  typedef logic [`CSROP_LEN-1:0]     csr_op_t;

  localparam alu_op_t ALUOP_NONE = '0;
  localparam exc_op_t EXCOP_NONE = '0;
  localparam csr_op_t CSROP_NONE = '0;

  localparam mem_op_t MEMOP_NONE = 4'd0;
  localparam mem_op_t MEMOP_LB   = 4'd1;  // first load code
  localparam mem_op_t MEMOP_LH   = 4'd2;
  localparam mem_op_t MEMOP_LW   = 4'd3;
  localparam mem_op_t MEMOP_LD   = 4'd4;
  localparam mem_op_t MEMOP_LBU  = 4'd5;
  localparam mem_op_t MEMOP_LHU  = 4'd6;
  localparam mem_op_t MEMOP_LWU  = 4'd7;  // last load code
  localparam mem_op_t MEMOP_SB   = 4'd8;
  localparam mem_op_t MEMOP_SH   = 4'd9;
  localparam mem_op_t MEMOP_SW   = 4'd10;
  localparam mem_op_t MEMOP_SD   = 4'd11;

  localparam pc_op_t PCOP_NONE = 4'd0;
  localparam pc_op_t PCOP_JAL  = 4'd1;
  localparam pc_op_t PCOP_JALR = 4'd2;
  localparam pc_op_t PCOP_BEQ  = 4'd3;
  localparam pc_op_t PCOP_BNE  = 4'd4;
  localparam pc_op_t PCOP_BLT  = 4'd5;
  localparam pc_op_t PCOP_BGE  = 4'd6;
  localparam pc_op_t PCOP_BLTU = 4'd7;
  localparam pc_op_t PCOP_BGEU = 4'd8;

endpackage

`default_nettype wire

/* list.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
id_ex_reg.sv
branch_unit.sv
pipe_ctrl.sv
idex_stage_top.sv
idex_stage_checker.sv
tb_clk_gen.sv
idex_stage_tb.sv

/* pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module pipe_ctrl import isa_pkg::*, pipe_pkg::*; (
  input  logic      mem_stall_i,
  input  logic      taken_i,
  input  reg_idx_t  id_rs1_idx_i,
  input  reg_idx_t  id_rs2_idx_i,
  input  reg_idx_t  ex_rd_idx_i,
  input  mem_op_t   ex_mem_op_i,
  output ctrl_bus_t stall_valid_o,
  output ctrl_bus_t flush_valid_o,
  output logic      redirect_valid_o
);

  logic ex_is_load;
  logic rd_match;
  logic load_use;

  assign ex_is_load = (ex_mem_op_i >= MEMOP_LB) && (ex_mem_op_i <= MEMOP_LWU);
  assign rd_match   = (ex_rd_idx_i == id_rs1_idx_i) || (ex_rd_idx_i == id_rs2_idx_i);
  assign load_use   = ex_is_load && (ex_rd_idx_i != '0) && rd_match;  // x0 never hazards

  always_comb begin
    stall_valid_o    = '0;
    flush_valid_o    = '0;
    redirect_valid_o = 1'b0;
    if (mem_stall_i) begin
      // freeze everything up to mem/wb
      stall_valid_o[`CTRLBUS_PC]     = 1'b1;
      stall_valid_o[`CTRLBUS_IF_ID]  = 1'b1;
      stall_valid_o[`CTRLBUS_ID_EX]  = 1'b1;
      stall_valid_o[`CTRLBUS_EX_MEM] = 1'b1;
      stall_valid_o[`CTRLBUS_MEM_WB] = 1'b1;
      stall_valid_o[`CTRLBUS_WB]     = 1'b0;  // wb still retires
    end else if (taken_i) begin
      redirect_valid_o              = 1'b1;
      flush_valid_o[`CTRLBUS_IF_ID] = 1'b1;  // kill wrong-path fetch
      flush_valid_o[`CTRLBUS_ID_EX] = 1'b1;  // and wrong-path decode
    end else if (load_use) begin
      stall_valid_o[`CTRLBUS_PC]    = 1'b1;
      stall_valid_o[`CTRLBUS_IF_ID] = 1'b1;
      flush_valid_o[`CTRLBUS_ID_EX] = 1'b1;  // bubble behind the load
    end
  end

endmodule

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package pipe_pkg;

  // bit order follows the CTRLBUS_* positions
  typedef logic [`CTRLBUS_LEN-1:0] ctrl_bus_t;

  // trap info rides along, never decoded here
  typedef logic [`TRAP_LEN-1:0] trap_bus_t;

endpackage

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;  // 20 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;  // release clear of the edge
  end

endmodule

`default_nettype wire
